/* src/exu_defs.svh */
`default_nettype none

`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data path and address width
`define EXU_XLEN 64

// architectural integer registers
`define EXU_NREGS 32

// bits needed to index one register
`define EXU_REG_AW 5

// bytes per memory word
`define EXU_LANES 8

// sequential pc increment, every instruction is 32 bits
`define EXU_PC_STEP 4

`endif

`default_nettype wire

/* src/exu_mem_pkg.sv */
`include "exu_defs.svh"
`default_nettype none

package exu_mem_pkg;

    // access size, bytes = 1 << size
    typedef enum logic [1:0] {SZ_B, SZ_H, SZ_W, SZ_D} size_e;

    // one memory word seen as byte lanes or as half lanes
    // lane 0 is the lowest address
    typedef union packed {
        logic [`EXU_LANES-1:0][7:0]     b;
        logic [`EXU_LANES/2-1:0][15:0]  h;
    } mem_word_u;

    // memory port strobes
    // zero address and zero mask when the op does not touch memory
    typedef struct packed {
        logic [`EXU_XLEN-1:0]  raddr;
        logic [`EXU_XLEN-1:0]  waddr;
        logic [`EXU_XLEN-1:0]  wdata;
        logic [`EXU_LANES-1:0] wmask;
    } mem_req_t;

endpackage

`default_nettype wire

/* src/exu_isa_pkg.sv */
`include "exu_defs.svh"
`default_nettype none

package exu_isa_pkg;

    // kept base integer operations, NOP is all zero
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD
    } op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND
    } alu_mode_e;

    // operand a source
    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;

    // operand b source
    typedef enum logic {OPB_RS2, OPB_IMM} opb_sel_e;

    // link writes pc plus step
    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_cond_e;

    // one decoded instruction as handed over from decode
    typedef struct packed {
        op_e                   op;
        logic [`EXU_REG_AW-1:0] rd;
        logic [`EXU_REG_AW-1:0] rs1;
        logic [`EXU_REG_AW-1:0] rs2;
        logic [`EXU_XLEN-1:0]   imm;
        logic [`EXU_XLEN-1:0]   pc;
    } issue_t;

    // per-op control bundle, shared by every unit of the stage
    typedef struct packed {
        alu_mode_e          alu_mode;
        opa_sel_e           opa_sel;
        opb_sel_e           opb_sel;
        wb_sel_e            wb_sel;
        logic               reg_wen;
        logic               mem_read;
        logic               mem_write;
        exu_mem_pkg::size_e size;
        logic               load_signed;
        br_cond_e           br_cond;
    } ctrl_t;

endpackage

`default_nettype wire

/* src/exu_op_decode.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"
`default_nettype none

module exu_op_decode (
    input  exu_isa_pkg::op_e    op,
    output exu_isa_pkg::ctrl_t  ctrl
);
    import exu_isa_pkg::*;
    import exu_mem_pkg::*;

    // everything off, also what unknown codes get
    localparam ctrl_t CTRL_IDLE = '{
        alu_mode:    ALU_ADD,
        opa_sel:     OPA_ZERO,
        opb_sel:     OPB_RS2,
        wb_sel:      WB_ALU,
        reg_wen:     1'b0,
        mem_read:    1'b0,
        mem_write:   1'b0,
        size:        SZ_D,
        load_signed: 1'b0,
        br_cond:     BR_NONE
    };

    // row builders, one per instruction class
    function automatic ctrl_t alu_row(alu_mode_e mode, opa_sel_e opa, opb_sel_e opb);
        ctrl_t c;
        c = CTRL_IDLE;
        c.alu_mode = mode;
        c.opa_sel  = opa;
        c.opb_sel  = opb;
        c.reg_wen  = 1'b1;
        return c;
    endfunction

    // alu forms the target, rd gets the link
    function automatic ctrl_t jump_row(opa_sel_e opa, br_cond_e cond);
        ctrl_t c;
        c = alu_row(ALU_ADD, opa, OPB_IMM);
        c.wb_sel  = WB_LINK;
        c.br_cond = cond;
        return c;
    endfunction

    // branch target and compare both live in next pc
    function automatic ctrl_t branch_row(br_cond_e cond);
        ctrl_t c;
        c = CTRL_IDLE;
        c.br_cond = cond;
        return c;
    endfunction

    // address is rs1 plus imm
    function automatic ctrl_t load_row(size_e sz, logic sgn);
        ctrl_t c;
        c = alu_row(ALU_ADD, OPA_RS1, OPB_IMM);
        c.wb_sel      = WB_LOAD;
        c.mem_read    = 1'b1;
        c.size        = sz;
        c.load_signed = sgn;
        return c;
    endfunction

    function automatic ctrl_t store_row(size_e sz);
        ctrl_t c;
        c = alu_row(ALU_ADD, OPA_RS1, OPB_IMM);
        c.reg_wen   = 1'b0;
        c.mem_write = 1'b1;
        c.size      = sz;
        return c;
    endfunction

    always_comb begin
        case (op)
            OP_ADD:   ctrl = alu_row(ALU_ADD,  OPA_RS1,  OPB_RS2);
            OP_SUB:   ctrl = alu_row(ALU_SUB,  OPA_RS1,  OPB_RS2);
            OP_SLL:   ctrl = alu_row(ALU_SLL,  OPA_RS1,  OPB_RS2);
            OP_SLT:   ctrl = alu_row(ALU_SLT,  OPA_RS1,  OPB_RS2);
            OP_SLTU:  ctrl = alu_row(ALU_SLTU, OPA_RS1,  OPB_RS2);
            OP_XOR:   ctrl = alu_row(ALU_XOR,  OPA_RS1,  OPB_RS2);
            OP_SRL:   ctrl = alu_row(ALU_SRL,  OPA_RS1,  OPB_RS2);
            OP_SRA:   ctrl = alu_row(ALU_SRA,  OPA_RS1,  OPB_RS2);
            OP_OR:    ctrl = alu_row(ALU_OR,   OPA_RS1,  OPB_RS2);
            OP_AND:   ctrl = alu_row(ALU_AND,  OPA_RS1,  OPB_RS2);
            OP_ADDI:  ctrl = alu_row(ALU_ADD,  OPA_RS1,  OPB_IMM);
            OP_SLTI:  ctrl = alu_row(ALU_SLT,  OPA_RS1,  OPB_IMM);
            OP_SLTIU: ctrl = alu_row(ALU_SLTU, OPA_RS1,  OPB_IMM);
            OP_XORI:  ctrl = alu_row(ALU_XOR,  OPA_RS1,  OPB_IMM);
            OP_ORI:   ctrl = alu_row(ALU_OR,   OPA_RS1,  OPB_IMM);
            OP_ANDI:  ctrl = alu_row(ALU_AND,  OPA_RS1,  OPB_IMM);
            OP_SLLI:  ctrl = alu_row(ALU_SLL,  OPA_RS1,  OPB_IMM);
            OP_SRLI:  ctrl = alu_row(ALU_SRL,  OPA_RS1,  OPB_IMM);
            OP_SRAI:  ctrl = alu_row(ALU_SRA,  OPA_RS1,  OPB_IMM);
            // lui is zero plus the upper immediate
            OP_LUI:   ctrl = alu_row(ALU_ADD,  OPA_ZERO, OPB_IMM);
            OP_AUIPC: ctrl = alu_row(ALU_ADD,  OPA_PC,   OPB_IMM);
            OP_JAL:   ctrl = jump_row(OPA_PC,  BR_JAL);
            OP_JALR:  ctrl = jump_row(OPA_RS1, BR_JALR);
            OP_BEQ:   ctrl = branch_row(BR_EQ);
            OP_BNE:   ctrl = branch_row(BR_NE);
            OP_BLT:   ctrl = branch_row(BR_LT);
            OP_BGE:   ctrl = branch_row(BR_GE);
            OP_BLTU:  ctrl = branch_row(BR_LTU);
            OP_BGEU:  ctrl = branch_row(BR_GEU);
            OP_LB:    ctrl = load_row(SZ_B, 1'b1);
            OP_LH:    ctrl = load_row(SZ_H, 1'b1);
            OP_LW:    ctrl = load_row(SZ_W, 1'b1);
            OP_LD:    ctrl = load_row(SZ_D, 1'b1);
            OP_LBU:   ctrl = load_row(SZ_B, 1'b0);
            OP_LHU:   ctrl = load_row(SZ_H, 1'b0);
            OP_LWU:   ctrl = load_row(SZ_W, 1'b0);
            OP_SB:    ctrl = store_row(SZ_B);
            OP_SH:    ctrl = store_row(SZ_H);
            OP_SW:    ctrl = store_row(SZ_W);
            OP_SD:    ctrl = store_row(SZ_D);
            default:  ctrl = CTRL_IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* src/exu_regfile.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"
`default_nettype none

module exu_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`EXU_REG_AW-1:0] rs1,
    input  logic [`EXU_REG_AW-1:0] rs2,
    input  logic [`EXU_REG_AW-1:0] rd,
    input  logic                   wen,
    input  logic [`EXU_XLEN-1:0]   wdata,
    output logic [`EXU_XLEN-1:0]   src1,
    output logic [`EXU_XLEN-1:0]   src2
);

    // x0 slot is cleared on reset and never written
    logic [`EXU_XLEN-1:0] regs [`EXU_NREGS-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            // writes to x0 are dropped here
            regs[rd] <= wdata;
        end
    end

    // combinational read, same-cycle write not forwarded
    assign src1 = regs[rs1];
    assign src2 = regs[rs2];

    // x0 stays zero no matter what was written before
    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (src1 == '0)
    ) else $error("x0 read back nonzero");

endmodule

`default_nettype wire

/* src/exu_alu.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"
`default_nettype none

module exu_alu (
    input  exu_isa_pkg::ctrl_t    ctrl,
    input  logic [`EXU_XLEN-1:0]  src1,
    input  logic [`EXU_XLEN-1:0]  src2,
    input  logic [`EXU_XLEN-1:0]  imm,
    input  logic [`EXU_XLEN-1:0]  pc,
    output logic [`EXU_XLEN-1:0]  result
);
    import exu_isa_pkg::*;

    logic [`EXU_XLEN-1:0] opa;
    logic [`EXU_XLEN-1:0] opb;
    // rv64 shifts only look at 6 bits
    logic [5:0]           shamt;
    logic                 lt_s;
    logic                 lt_u;

    // operand a
    always_comb begin
        case (ctrl.opa_sel)
            OPA_RS1: opa = src1;
            OPA_PC:  opa = pc;
            default: opa = '0;
        endcase
    end

    assign opb   = (ctrl.opb_sel == OPB_IMM) ? imm : src2;
    assign shamt = opb[5:0];

    assign lt_s = $signed(opa) < $signed(opb);
    assign lt_u = opa < opb;

    always_comb begin
        case (ctrl.alu_mode)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_SLL:  result = opa << shamt;
            ALU_SRL:  result = opa >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = $signed(opa) >>> shamt;
            // compares give 0 or 1
            ALU_SLT:  result = `EXU_XLEN'(lt_s);
            ALU_SLTU: result = `EXU_XLEN'(lt_u);
            ALU_XOR:  result = opa ^ opb;
            ALU_OR:   result = opa | opb;
            ALU_AND:  result = opa & opb;
            default:  result = opa + opb;
        endcase
    end

endmodule

`default_nettype wire

/* src/exu_lsu.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"
`default_nettype none

module exu_lsu (
    input  logic                    rst_n,
    input  exu_isa_pkg::ctrl_t      ctrl,
    input  logic [`EXU_XLEN-1:0]    addr,
    input  logic [`EXU_XLEN-1:0]    src2,
    input  logic [`EXU_XLEN-1:0]    mem_rdata,
    output exu_mem_pkg::mem_req_t   mem_req,
    output logic [`EXU_XLEN-1:0]    load_data
);
    import exu_isa_pkg::*;
    import exu_mem_pkg::*;

    localparam int LANE_W = $clog2(`EXU_LANES);

    logic [LANE_W-1:0]    lane;
    logic [`EXU_LANES-1:0] base_mask;
    logic [LANE_W-1:0]    align_mask;
    logic [`EXU_XLEN-1:0] size_bits;
    logic                 store_act;
    mem_word_u            word;
    logic [`EXU_XLEN-1:0] raw;
    logic [`EXU_XLEN-1:0] fill;
    logic                 sign;

    assign lane = addr[LANE_W-1:0];

    // lanes covered from lane 0, and the low address bits that must be clear
    always_comb begin
        case (ctrl.size)
            SZ_B:    begin base_mask = 8'h01; align_mask = 3'b000; end
            SZ_H:    begin base_mask = 8'h03; align_mask = 3'b001; end
            SZ_W:    begin base_mask = 8'h0f; align_mask = 3'b011; end
            default: begin base_mask = 8'hff; align_mask = 3'b111; end
        endcase
    end

    // byte mask widened to bits
    always_comb begin
        for (int i = 0; i < `EXU_LANES; i++) begin
            size_bits[i*8 +: 8] = {8{base_mask[i]}};
        end
    end

    // no strobes out of reset
    assign store_act = ctrl.mem_write && rst_n;

    always_comb begin
        mem_req.raddr = ctrl.mem_read ? addr : '0;
        mem_req.waddr = ctrl.mem_write ? addr : '0;
        // low bytes of src2 moved up to the lane, rest stays zero
        mem_req.wdata = store_act ? (src2 & size_bits) << {lane, 3'b000} : '0;
        mem_req.wmask = store_act ? base_mask << lane : '0;
    end

    assign word = mem_rdata;

    // pick the lane, remember its top bit for sign extension
    always_comb begin
        case (ctrl.size)
            SZ_B: begin
                raw  = `EXU_XLEN'(word.b[lane]);
                sign = word.b[lane][7];
                fill = {{56{1'b1}}, 8'h00};
            end
            SZ_H: begin
                raw  = `EXU_XLEN'(word.h[lane[LANE_W-1:1]]);
                sign = word.h[lane[LANE_W-1:1]][15];
                fill = {{48{1'b1}}, 16'h0000};
            end
            SZ_W: begin
                // two halves of the upper or lower word
                raw  = `EXU_XLEN'({word.h[{lane[2], 1'b1}], word.h[{lane[2], 1'b0}]});
                sign = word.h[{lane[2], 1'b1}][15];
                fill = {{32{1'b1}}, 32'h0};
            end
            default: begin
                raw  = mem_rdata;
                sign = 1'b0;
                fill = '0;
            end
        endcase
    end

    assign load_data = !ctrl.mem_read ? '0 :
                       (ctrl.load_signed && sign) ? (raw | fill) : raw;

    // address comes from the alu, size from decode
    always_comb begin
        if (rst_n && (ctrl.mem_read || ctrl.mem_write)) begin
            a_aligned: assert final ((lane & align_mask) == '0)
                else $error("misaligned access at %h", addr);
        end
    end

endmodule

`default_nettype wire

/* src/exu_next_pc.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"
`default_nettype none

module exu_next_pc (
    input  exu_isa_pkg::ctrl_t    ctrl,
    input  logic [`EXU_XLEN-1:0]  src1,
    input  logic [`EXU_XLEN-1:0]  src2,
    input  logic [`EXU_XLEN-1:0]  imm,
    input  logic [`EXU_XLEN-1:0]  pc,
    input  logic [`EXU_XLEN-1:0]  alu_result,
    output logic [`EXU_XLEN-1:0]  dnpc
);
    import exu_isa_pkg::*;

    logic [`EXU_XLEN-1:0] snpc;
    logic [`EXU_XLEN-1:0] br_target;
    logic                 eq;
    logic                 lt_s;
    logic                 lt_u;

    assign snpc      = pc + `EXU_PC_STEP;
    assign br_target = pc + imm;

    // direct register compares
    assign eq   = src1 == src2;
    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   dnpc = eq    ? br_target : snpc;
            BR_NE:   dnpc = !eq   ? br_target : snpc;
            BR_LT:   dnpc = lt_s  ? br_target : snpc;
            // bge is signed
            BR_GE:   dnpc = !lt_s ? br_target : snpc;
            BR_LTU:  dnpc = lt_u  ? br_target : snpc;
            BR_GEU:  dnpc = !lt_u ? br_target : snpc;
            // alu already holds pc plus imm
            BR_JAL:  dnpc = alu_result;
            // jalr target drops bit 0
            BR_JALR: dnpc = {alu_result[`EXU_XLEN-1:1], 1'b0};
            default: dnpc = snpc;
        endcase
    end

endmodule

`default_nettype wire

/* src/exu_top.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"
`default_nettype none

module exu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exu_isa_pkg::issue_t    issue,
    input  logic [`EXU_XLEN-1:0]   mem_rdata,
    output exu_mem_pkg::mem_req_t  mem_req,
    output logic [`EXU_XLEN-1:0]   dnpc
);
    import exu_isa_pkg::*;

    ctrl_t                ctrl;
    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;
    logic [`EXU_XLEN-1:0] alu_result;
    logic [`EXU_XLEN-1:0] load_data;
    logic [`EXU_XLEN-1:0] wb_data;

    exu_op_decode u_decode (
        .op   (issue.op),
        .ctrl (ctrl)
    );

    exu_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (issue.rs1),
        .rs2   (issue.rs2),
        .rd    (issue.rd),
        .wen   (ctrl.reg_wen),
        .wdata (wb_data),
        .src1  (src1),
        .src2  (src2)
    );

    exu_alu u_alu (
        .ctrl   (ctrl),
        .src1   (src1),
        .src2   (src2),
        .imm    (issue.imm),
        .pc     (issue.pc),
        .result (alu_result)
    );

    // alu result doubles as the memory address
    exu_lsu u_lsu (
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .addr      (alu_result),
        .src2      (src2),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .load_data (load_data)
    );

    exu_next_pc u_next_pc (
        .ctrl       (ctrl),
        .src1       (src1),
        .src2       (src2),
        .imm        (issue.imm),
        .pc         (issue.pc),
        .alu_result (alu_result),
        .dnpc       (dnpc)
    );

    // writeback source
    always_comb begin
        case (ctrl.wb_sel)
            WB_LOAD: wb_data = load_data;
            WB_LINK: wb_data = issue.pc + `EXU_PC_STEP;
            default: wb_data = alu_result;
        endcase
    end

    // a result written this cycle is what rs1 sees next cycle
    a_wb_visible: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl.reg_wen && issue.rd != '0) |=>
            (issue.rs1 != $past(issue.rd) || src1 == $past(wb_data))
    ) else $error("writeback not visible to the next instruction");

endmodule

`default_nettype wire

/* test/tb_exu_model.svh */
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

// model memory: each word is a hash of the whole address
function automatic logic [63:0] mem_word(input logic [63:0] addr, input logic [63:0] k0,
                                         input logic [63:0] k1);
    logic [63:0] x;
    x = (addr ^ k0) * k1;
    x = x ^ (x >> 31);
    x = (x * k1) ^ {addr[31:0], addr[63:32]};
    return x ^ (x >> 29);
endfunction

function automatic int size_bytes(input op_e op);
    case (op)
        OP_LB, OP_LBU, OP_SB: return 1;
        OP_LH, OP_LHU, OP_SH: return 2;
        OP_LW, OP_LWU, OP_SW: return 4;
        default:              return 8;
    endcase
endfunction

function automatic logic is_load(input op_e op);
    return op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
endfunction

function automatic logic is_store(input op_e op);
    return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
endfunction

function automatic logic is_branch(input op_e op);
    return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
endfunction

// everything but stores, branches and nop has a destination
function automatic logic writes_reg(input op_e op);
    return !(is_store(op) || is_branch(op) || op == OP_NOP);
endfunction

// isa result of the arithmetic forms, lui and auipc
function automatic logic [63:0] alu_model(input op_e op, input logic [63:0] a,
                                          input logic [63:0] b, input logic [63:0] imm,
                                          input logic [63:0] pc);
    case (op)
        OP_ADD:   return a + b;
        OP_SUB:   return a - b;
        OP_SLL:   return a << b[5:0];
        OP_SRL:   return a >> b[5:0];
        OP_SRA:   return $signed(a) >>> b[5:0];
        OP_SLT:   return {63'd0, $signed(a) < $signed(b)};
        OP_SLTU:  return {63'd0, a < b};
        OP_XOR:   return a ^ b;
        OP_OR:    return a | b;
        OP_AND:   return a & b;
        OP_ADDI:  return a + imm;
        OP_SLTI:  return {63'd0, $signed(a) < $signed(imm)};
        OP_SLTIU: return {63'd0, a < imm};
        OP_XORI:  return a ^ imm;
        OP_ORI:   return a | imm;
        OP_ANDI:  return a & imm;
        OP_SLLI:  return a << imm[5:0];
        OP_SRLI:  return a >> imm[5:0];
        OP_SRAI:  return $signed(a) >>> imm[5:0];
        OP_LUI:   return imm;
        OP_AUIPC: return pc + imm;
        default:  return 64'd0;
    endcase
endfunction

// bge and bgeu follow the isa, signed and unsigned
function automatic logic branch_taken(input op_e op, input logic [63:0] a,
                                      input logic [63:0] b);
    case (op)
        OP_BEQ:  return a == b;
        OP_BNE:  return a != b;
        OP_BLT:  return $signed(a) < $signed(b);
        OP_BGE:  return $signed(a) >= $signed(b);
        OP_BLTU: return a < b;
        OP_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// gather bytes from the lane upward, then extend
function automatic logic [63:0] load_extract(input op_e op, input logic [63:0] word,
                                             input logic [2:0] lane);
    mem_word_u w;
    logic [63:0] v;
    int nb;
    w = word;
    nb = size_bytes(op);
    v = '0;
    for (int i = 0; i < nb; i++) begin
        v[i*8 +: 8] = w.b[int'(lane) + i];
    end
    if (op inside {OP_LB, OP_LH, OP_LW} && v[nb*8-1]) begin
        v = v | ~((64'd1 << (nb * 8)) - 64'd1);
    end
    return v;
endfunction

function automatic logic [7:0] store_mask(input op_e op, input logic [2:0] lane);
    return 8'((16'd1 << size_bytes(op)) - 16'd1) << lane;
endfunction

// low bytes of the register land at the lane, other lanes stay zero
function automatic logic [63:0] store_data(input op_e op, input logic [63:0] val,
                                           input logic [2:0] lane);
    logic [63:0] d;
    d = '0;
    for (int i = 0; i < size_bytes(op); i++) begin
        d[(int'(lane) + i)*8 +: 8] = val[i*8 +: 8];
    end
    return d;
endfunction

`endif

/* test/tb_exu_top.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"
`default_nettype none

module tb_exu_top;
    import exu_isa_pkg::*;
    import exu_mem_pkg::*;

    `include "tb_exu_model.svh"

    localparam int N_INSTR    = 600;
    localparam int RST_CYCLES = 8;
    localparam int CLK_NS     = 10;

    logic                 clk;
    logic                 rst_n;
    issue_t               issue;
    logic [`EXU_XLEN-1:0] mem_rdata;
    mem_req_t             mem_req;
    logic [`EXU_XLEN-1:0] dnpc;

    // hash constants of the model memory
    logic [63:0] hash_k0;
    logic [63:0] hash_k1;
    // architectural state as the model sees it
    logic [63:0] shadow [`EXU_NREGS];
    logic [63:0] pc_cur;
    int          n_issued;

    // expectations for the instruction on issue
    logic [63:0] exp_dnpc;
    logic [63:0] exp_raddr;
    logic [63:0] exp_waddr;
    logic [63:0] exp_wdata;
    logic [7:0]  exp_wmask;

    exu_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .dnpc      (dnpc)
    );

    // memory answers in the same cycle
    assign mem_rdata = mem_word(mem_req.raddr, hash_k0, hash_k1);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    task automatic report_mismatch(input string check, input logic [5:0] opc,
                                   input logic [63:0] exp, input logic [63:0] act);
        op_e o;
        o = op_e'(opc);
        $display("MISMATCH %s op %s expected %h actual %h at %0t", check, o.name(), exp, act,
                 $time);
        $display("RESULT: FAIL");
        $fatal(1, "first failing check stops the run");
    endtask

    // model result computed up front, issue and expectations land on one edge
    task automatic run_instr(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [63:0] imm);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] addr;
        logic [63:0] res;
        logic [63:0] npc;
        a = shadow[rs1];
        b = shadow[rs2];
        addr = a + imm;
        npc = pc_cur + `EXU_PC_STEP;
        res = alu_model(op, a, b, imm, pc_cur);
        if (is_load(op))
            res = load_extract(op, mem_word(addr, hash_k0, hash_k1), addr[2:0]);
        // link is the sequential pc
        if (op == OP_JAL || op == OP_JALR)
            res = pc_cur + `EXU_PC_STEP;
        if (op == OP_JAL)
            npc = pc_cur + imm;
        if (op == OP_JALR)
            npc = (a + imm) & ~64'd1;
        if (is_branch(op) && branch_taken(op, a, b))
            npc = pc_cur + imm;
        @(posedge clk);
        issue <= '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, pc: pc_cur};
        exp_dnpc  <= npc;
        exp_raddr <= is_load(op) ? addr : 64'd0;
        exp_waddr <= is_store(op) ? addr : 64'd0;
        exp_wmask <= is_store(op) ? store_mask(op, addr[2:0]) : 8'd0;
        exp_wdata <= is_store(op) ? store_data(op, b, addr[2:0]) : 64'd0;
        // x0 never changes
        if (writes_reg(op) && rd != 5'd0)
            shadow[rd] = res;
        pc_cur = npc;
        n_issued++;
    endtask

    // sd of one register at a random aligned address
    task automatic store_reg(input logic [4:0] r);
        logic [4:0] base;
        base = 5'($urandom);
        run_instr(OP_SD, 5'd0, base, r, (rand64() & ~64'd7) - shadow[base]);
    endtask

    task automatic random_step();
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] r;
        logic [63:0] imm;
        int          nb;
        op = op_e'($urandom_range(40, 1));
        rd = 5'($urandom);
        rs1 = 5'($urandom);
        // equal operands now and then so beq and bge see ties
        rs2 = ($urandom_range(3, 0) == 0) ? rs1 : 5'($urandom);
        r = rand64();
        imm = {{52{r[11]}}, r[11:0]};
        if (op inside {OP_LUI, OP_AUIPC, OP_JAL})
            imm = {{32{r[31]}}, r[31:12], 12'h000};
        if (is_load(op) || is_store(op)) begin
            nb = size_bytes(op);
            imm = (r & ~64'(nb - 1)) - shadow[rs1];
        end
        run_instr(op, rd, rs1, rs2, imm);
        // every result goes out through a store
        if (writes_reg(op))
            store_reg(rd);
    endtask

    initial begin
        void'($urandom(50));
        hash_k0 = rand64();
        hash_k1 = rand64() | 64'd1;
        rst_n = 1'b0;
        issue = '0;
        pc_cur = 64'h0;
        n_issued = 0;
        // nop at pc 0 right after reset
        exp_dnpc = `EXU_PC_STEP;
        exp_raddr = '0;
        exp_waddr = '0;
        exp_wdata = '0;
        exp_wmask = '0;
        for (int i = 0; i < `EXU_NREGS; i++) begin
            shadow[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        pc_cur = 64'h8000_0000;
        // cleared registers store zero
        repeat (3) store_reg(5'($urandom_range(31, 1)));
        // seed every register from model memory
        for (int i = 1; i < `EXU_NREGS; i++) begin
            run_instr(OP_LD, 5'(i), 5'd0, 5'd0, rand64() & ~64'd7);
        end
        while (n_issued < N_INSTR) begin
            random_step();
        end
        run_instr(OP_NOP, 5'd0, 5'd0, 5'd0, 64'd0);
        repeat (2) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #((RST_CYCLES + N_INSTR + 50) * CLK_NS * 2);
        $display("timeout: the instruction stream did not complete");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    a_dnpc: assert property (@(posedge clk) disable iff (!rst_n) dnpc == exp_dnpc)
        else report_mismatch("next pc", $sampled(issue.op), $sampled(exp_dnpc),
                             $sampled(dnpc));

    a_raddr: assert property (@(posedge clk) disable iff (!rst_n) mem_req.raddr == exp_raddr)
        else report_mismatch("read address", $sampled(issue.op), $sampled(exp_raddr),
                             $sampled(mem_req.raddr));

    a_waddr: assert property (@(posedge clk) disable iff (!rst_n) mem_req.waddr == exp_waddr)
        else report_mismatch("write address", $sampled(issue.op), $sampled(exp_waddr),
                             $sampled(mem_req.waddr));

    // covers every result through later stores, x0 included
    a_wdata: assert property (@(posedge clk) disable iff (!rst_n) mem_req.wdata == exp_wdata)
        else report_mismatch("write data", $sampled(issue.op), $sampled(exp_wdata),
                             $sampled(mem_req.wdata));

    a_wmask: assert property (@(posedge clk) disable iff (!rst_n) mem_req.wmask == exp_wmask)
        else report_mismatch("write mask", $sampled(issue.op), 64'($sampled(exp_wmask)),
                             64'($sampled(mem_req.wmask)));

    a_idle_wmask: assert property (@(posedge clk) disable iff (!rst_n)
        !is_store(issue.op) |-> mem_req.wmask == '0)
        else report_mismatch("idle mask", $sampled(issue.op), 64'd0,
                             64'($sampled(mem_req.wmask)));

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
+incdir+test
src/exu_mem_pkg.sv
src/exu_isa_pkg.sv
src/exu_op_decode.sv
src/exu_regfile.sv
src/exu_alu.sv
src/exu_lsu.sv
src/exu_next_pc.sv
src/exu_top.sv
test/tb_exu_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_exu_top -f flist.f -o sim_exu \
    || { echo "build failed"; exit 1; }
{ ./obj_dir/sim_exu > sim.log 2>&1 || echo "RESULT: FAIL" >> sim.log; } && cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
